//--- design/retire_pkg.sv
package retire_pkg;

    // csr numbers.
    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_SAVE0  = 14'h030;
    localparam logic [13:0] CSR_SAVE1  = 14'h031;
    localparam logic [13:0] CSR_SAVE2  = 14'h032;
    localparam logic [13:0] CSR_SAVE3  = 14'h033;

    localparam logic [5:0] ECODE_SYS = 6'h0b; // syscall exception code.

    // bits software may change through csrwr / csrxchg.
    localparam logic [31:0] CRMD_WMASK   = 32'h0000_0007; // plv and ie.
    localparam logic [31:0] PRMD_WMASK   = 32'h0000_0007; // pplv and pie.
    localparam logic [31:0] ESTAT_WMASK  = 32'h0000_0003; // software interrupt bits.
    localparam logic [31:0] EENTRY_WMASK = 32'hffff_ffc0; // 64-byte aligned entry.

    localparam logic [31:0] CRMD_RESET = 32'h0000_0008; // da set, plv 0, ie 0.

    // estat fields written on exception entry.
    localparam int ESTAT_ECODE_LSB    = 16;
    localparam int ESTAT_ESUBCODE_LSB = 22;

    typedef struct packed {
        logic [31:0] pc;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] result;
        logic        csr_we;
        logic        csr_re;
        logic [13:0] csr_num;
        logic [31:0] csr_wmask;
        logic [31:0] csr_wvalue;
        logic        syscall;
        logic        ertn;
    } mem_wb_bus_t;

    typedef struct packed {
        logic        rf_we;
        logic [4:0]  rf_waddr;
        logic [31:0] rf_wdata;
    } wb_id_bus_t;

    typedef struct packed {
        logic        re;
        logic        we;
        logic [13:0] num;
        logic [31:0] wmask;
        logic [31:0] wvalue;
    } csr_req_t;

    // esubcode is always zero for syscall, so it is not carried.
    typedef struct packed {
        logic        ex;
        logic        ertn;
        logic [31:0] pc;
        logic [5:0]  ecode;
    } exc_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] target;
    } flush_t;

endpackage

//--- design/wb_stage.sv
`timescale 1ns/1ps

module wb_stage import retire_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    output logic        wb_allowin,
    input  logic        mem_wb_valid,
    input  mem_wb_bus_t mem_wb_bus,

    output csr_req_t    csr_req,
    input  logic [31:0] csr_rvalue,
    output exc_req_t    exc_req,

    output logic        rf_we,
    output logic [4:0]  rf_waddr,
    output logic [31:0] rf_wdata,

    output wb_id_bus_t  wb_id_bus,

    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    logic        wb_valid;
    mem_wb_bus_t wb_bus;
    logic        csr_rd;

    assign wb_allowin = 1'b1; // retire never stalls.

    always_ff @(posedge clk) begin
        if (!resetn) begin
            wb_valid <= 1'b0;
        end else if (wb_allowin) begin
            wb_valid <= mem_wb_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_wb_valid && wb_allowin) begin
            wb_bus <= mem_wb_bus;
        end
    end

    // an exchange also reads so the old value goes to rd.
    assign csr_rd = wb_valid & (wb_bus.csr_re | wb_bus.csr_we);

    always_comb begin
        csr_req.re     = csr_rd;
        csr_req.we     = wb_valid & wb_bus.csr_we & ~wb_bus.syscall;
        csr_req.num    = wb_bus.csr_num;
        csr_req.wmask  = wb_bus.csr_wmask;
        csr_req.wvalue = wb_bus.csr_wvalue;
    end

    always_comb begin
        exc_req.ex    = wb_valid & wb_bus.syscall;
        exc_req.ertn  = wb_valid & wb_bus.ertn;
        exc_req.pc    = wb_bus.pc;
        exc_req.ecode = wb_bus.syscall ? ECODE_SYS : 6'h00;
    end

    assign rf_we    = wb_valid & wb_bus.gr_we & ~wb_bus.syscall;
    assign rf_waddr = wb_bus.dest;
    assign rf_wdata = csr_rd ? csr_rvalue : wb_bus.result;

    // forwarding to decode.
    always_comb begin
        wb_id_bus.rf_we    = rf_we;
        wb_id_bus.rf_waddr = rf_waddr;
        wb_id_bus.rf_wdata = rf_wdata;
    end

    assign debug_wb_pc       = wb_bus.pc;
    assign debug_wb_rf_we    = {4{rf_we}};
    assign debug_wb_rf_wnum  = wb_bus.dest;
    assign debug_wb_rf_wdata = rf_wdata;

    // the valid bit must resolve once reset has been applied.
    a_valid_known: assert property (
        @(posedge clk) disable iff (!resetn) !$isunknown(wb_valid)
    );

    // decode never marks one instruction as both syscall and ertn.
    a_sys_ertn_excl: assert property (
        @(posedge clk) disable iff (!resetn)
        wb_valid |-> !(wb_bus.syscall && wb_bus.ertn)
    );

endmodule

//--- design/csr_file.sv
`timescale 1ns/1ps

module csr_file import retire_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    input  csr_req_t    csr_req,
    output logic [31:0] csr_rvalue,

    input  exc_req_t    exc_req,
    output flush_t      flush
);

    logic [31:0] crmd;
    logic [31:0] prmd;
    logic [31:0] estat;
    logic [31:0] era;
    logic [31:0] eentry;
    logic [31:0] save [4];
    logic [31:0] rd_mux;

    // only bits in both masks take the new value.
    function automatic logic [31:0] merge(
        input logic [31:0] old_value,
        input logic [31:0] wmask,
        input logic [31:0] wvalue,
        input logic [31:0] field_mask
    );
        logic [31:0] m;
        m = wmask & field_mask;
        return (old_value & ~m) | (wvalue & m);
    endfunction

    always_comb begin
        case (csr_req.num)
            CSR_CRMD:   rd_mux = crmd;
            CSR_PRMD:   rd_mux = prmd;
            CSR_ESTAT:  rd_mux = estat;
            CSR_ERA:    rd_mux = era;
            CSR_EENTRY: rd_mux = eentry;
            CSR_SAVE0:  rd_mux = save[0];
            CSR_SAVE1:  rd_mux = save[1];
            CSR_SAVE2:  rd_mux = save[2];
            CSR_SAVE3:  rd_mux = save[3];
            default:    rd_mux = 32'h0; // unimplemented csr.
        endcase
    end

    assign csr_rvalue = csr_req.re ? rd_mux : 32'h0;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            crmd    <= CRMD_RESET;
            prmd    <= 32'h0;
            estat   <= 32'h0;
            era     <= 32'h0;
            eentry  <= 32'h0;
            save[0] <= 32'h0;
            save[1] <= 32'h0;
            save[2] <= 32'h0;
            save[3] <= 32'h0;
        end else begin
            if (csr_req.we) begin
                case (csr_req.num)
                    CSR_CRMD: begin
                        crmd <= merge(crmd, csr_req.wmask, csr_req.wvalue, CRMD_WMASK);
                    end
                    CSR_PRMD: begin
                        prmd <= merge(prmd, csr_req.wmask, csr_req.wvalue, PRMD_WMASK);
                    end
                    CSR_ESTAT: begin
                        estat <= merge(estat, csr_req.wmask, csr_req.wvalue, ESTAT_WMASK);
                    end
                    CSR_ERA: begin
                        era <= merge(era, csr_req.wmask, csr_req.wvalue, 32'hffff_ffff);
                    end
                    CSR_EENTRY: begin
                        eentry <= merge(eentry, csr_req.wmask, csr_req.wvalue,
                                        EENTRY_WMASK);
                    end
                    CSR_SAVE0: begin
                        save[0] <= merge(save[0], csr_req.wmask, csr_req.wvalue, 32'hffff_ffff);
                    end
                    CSR_SAVE1: begin
                        save[1] <= merge(save[1], csr_req.wmask, csr_req.wvalue, 32'hffff_ffff);
                    end
                    CSR_SAVE2: begin
                        save[2] <= merge(save[2], csr_req.wmask, csr_req.wvalue, 32'hffff_ffff);
                    end
                    CSR_SAVE3: begin
                        save[3] <= merge(save[3], csr_req.wmask, csr_req.wvalue, 32'hffff_ffff);
                    end
                    default: begin
                    end
                endcase
            end

            // exception state changes come last so they win over a csr write.
            if (exc_req.ex) begin
                prmd[2:0] <= crmd[2:0];                   // save plv and ie.
                crmd[2:0] <= 3'b000;                      // kernel, interrupts off.
                era       <= exc_req.pc;
                estat[ESTAT_ECODE_LSB +: 6]    <= exc_req.ecode;
                estat[ESTAT_ESUBCODE_LSB +: 9] <= 9'h000;
            end else if (exc_req.ertn) begin
                crmd[2:0] <= prmd[2:0];                   // restore plv and ie.
            end
        end
    end

    always_comb begin
        flush.valid  = exc_req.ex | exc_req.ertn;
        flush.target = exc_req.ex ? eentry : era;
    end

    // the stage must never raise entry and return in one cycle.
    a_ex_ertn_excl: assert property (
        @(posedge clk) disable iff (!resetn) !(exc_req.ex && exc_req.ertn)
    );

endmodule

//--- design/reg_file.sv
`timescale 1ns/1ps

module reg_file (
    input  logic        clk,

    input  logic        we,
    input  logic [4:0]  waddr,
    input  logic [31:0] wdata,

    input  logic [4:0]  raddr1,
    output logic [31:0] rdata1,
    input  logic [4:0]  raddr2,
    output logic [31:0] rdata2
);

    logic [31:0] regs [32];

    // r0 is never stored.
    always_ff @(posedge clk) begin
        if (we && (waddr != 5'd0)) begin
            regs[waddr] <= wdata;
        end
    end

    // read ports see the old value until the edge.
    always_comb begin
        if (raddr1 == 5'd0) begin
            rdata1 = 32'h0;
        end else begin
            rdata1 = regs[raddr1];
        end
    end

    always_comb begin
        if (raddr2 == 5'd0) begin
            rdata2 = 32'h0;
        end else begin
            rdata2 = regs[raddr2];
        end
    end

endmodule

//--- design/retire_top.sv
`timescale 1ns/1ps

module retire_top import retire_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    output logic        wb_allowin,
    input  logic        mem_wb_valid,
    input  mem_wb_bus_t mem_wb_bus,

    output wb_id_bus_t  wb_id_bus,

    input  logic [4:0]  rf_raddr1,
    input  logic [4:0]  rf_raddr2,
    output logic [31:0] rf_rdata1,
    output logic [31:0] rf_rdata2,

    output flush_t      flush,

    output logic [31:0] debug_wb_pc,
    output logic [3:0]  debug_wb_rf_we,
    output logic [4:0]  debug_wb_rf_wnum,
    output logic [31:0] debug_wb_rf_wdata
);

    csr_req_t    csr_req;
    logic [31:0] csr_rvalue;
    exc_req_t    exc_req;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    wb_stage u_wb_stage (
        .clk               (clk),
        .resetn            (resetn),
        .wb_allowin        (wb_allowin),
        .mem_wb_valid      (mem_wb_valid),
        .mem_wb_bus        (mem_wb_bus),
        .csr_req           (csr_req),
        .csr_rvalue        (csr_rvalue),
        .exc_req           (exc_req),
        .rf_we             (rf_we),
        .rf_waddr          (rf_waddr),
        .rf_wdata          (rf_wdata),
        .wb_id_bus         (wb_id_bus),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    csr_file u_csr_file (
        .clk        (clk),
        .resetn     (resetn),
        .csr_req    (csr_req),
        .csr_rvalue (csr_rvalue),
        .exc_req    (exc_req),
        .flush      (flush)
    );

    reg_file u_reg_file (
        .clk    (clk),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata),
        .raddr1 (rf_raddr1),
        .rdata1 (rf_rdata1),
        .raddr2 (rf_raddr2),
        .rdata2 (rf_rdata2)
    );

endmodule

//--- bench/tb_retire_top.sv
`timescale 1ns/1ps

module tb_retire_top import retire_pkg::*; ();

    localparam int ALLOWIN_TIMEOUT = 20;
    localparam int STREAM_LEN      = 300;

    logic        clk;
    logic        resetn;
    logic        wb_allowin;
    logic        mem_wb_valid;
    mem_wb_bus_t mem_wb_bus;
    wb_id_bus_t  wb_id_bus;
    logic [4:0]  rf_raddr1;
    logic [4:0]  rf_raddr2;
    logic [31:0] rf_rdata1;
    logic [31:0] rf_rdata2;
    flush_t      flush;
    logic [31:0] debug_wb_pc;
    logic [3:0]  debug_wb_rf_we;
    logic [4:0]  debug_wb_rf_wnum;
    logic [31:0] debug_wb_rf_wdata;

    logic [31:0] m_gr [32];
    logic        m_gr_known [32]; // register file has no reset.
    logic [31:0] m_csr [logic [13:0]];
    logic [13:0] csr_list [10] = '{CSR_CRMD, CSR_PRMD, CSR_ESTAT, CSR_ERA, CSR_EENTRY,
                                   CSR_SAVE0, CSR_SAVE1, CSR_SAVE2, CSR_SAVE3, 14'h2a7};

    retire_top u_retire_top (
        .clk               (clk),
        .resetn            (resetn),
        .wb_allowin        (wb_allowin),
        .mem_wb_valid      (mem_wb_valid),
        .mem_wb_bus        (mem_wb_bus),
        .wb_id_bus         (wb_id_bus),
        .rf_raddr1         (rf_raddr1),
        .rf_raddr2         (rf_raddr2),
        .rf_rdata1         (rf_rdata1),
        .rf_rdata2         (rf_rdata2),
        .flush             (flush),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_we    (debug_wb_rf_we),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum),
        .debug_wb_rf_wdata (debug_wb_rf_wdata)
    );

    always #5 clk = ~clk;

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    task automatic check_id_bus(input string name, input wb_id_bus_t exp,
                                input wb_id_bus_t act);
        if (act !== exp) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    // target only has a meaning while the redirect is valid.
    task automatic check_flush(input string name, input flush_t exp, input flush_t act);
        if (act.valid !== exp.valid || (exp.valid && act.target !== exp.target)) begin
            abort_run($sformatf("error %s: expected %h, actual %h", name, exp, act));
        end
    endtask

    function automatic logic [31:0] writable_bits(input logic [13:0] num);
        case (num)
            CSR_CRMD:   return CRMD_WMASK;
            CSR_PRMD:   return PRMD_WMASK;
            CSR_ESTAT:  return ESTAT_WMASK;
            CSR_EENTRY: return EENTRY_WMASK;
            default:    return 32'hffff_ffff; // era and save registers.
        endcase
    endfunction

    function automatic logic [31:0] expected_csr(input logic [13:0] num);
        if (m_csr.exists(num)) begin
            return m_csr[num];
        end
        return 32'h0;
    endfunction

    function automatic logic [31:0] expected_gr(input logic [4:0] addr);
        return (addr == 5'd0) ? 32'h0 : m_gr[addr];
    endfunction

    task automatic reset_model();
        m_csr.delete();
        m_csr[CSR_CRMD] = CRMD_RESET;
        for (int i = 1; i < 10; i++) begin
            m_csr[csr_list[i]] = 32'h0;
        end
        m_csr.delete(14'h2a7); // the unknown number stays unimplemented.
        for (int i = 0; i < 32; i++) begin
            m_gr_known[i] = 1'b0;
        end
    endtask

    function automatic logic [13:0] pick_csr();
        int sel;
        sel = $urandom_range(9, 0);
        return csr_list[sel];
    endfunction

    // kinds: 0 alu, 1 csrrd, 2 csrwr, 3 csrxchg, 4 syscall, 5 ertn.
    function automatic mem_wb_bus_t make_instr(input int kind);
        mem_wb_bus_t b;
        b            = '0;
        b.pc         = {30'($urandom()), 2'b00};
        b.dest       = 5'($urandom());
        b.result     = $urandom();
        b.csr_num    = pick_csr();
        b.csr_wvalue = $urandom();
        case (kind)
            0: b.gr_we = 1'($urandom());
            1: begin
                b.gr_we  = 1'b1;
                b.csr_re = 1'b1;
            end
            2: begin
                b.gr_we     = 1'b1;
                b.csr_we    = 1'b1;
                b.csr_wmask = 32'hffff_ffff;
            end
            3: begin
                b.gr_we     = 1'b1;
                b.csr_we    = 1'b1;
                b.csr_wmask = $urandom();
            end
            4: begin
                b.gr_we     = 1'($urandom());
                b.csr_we    = 1'($urandom()); // blocked by the syscall.
                b.csr_wmask = $urandom();
                b.syscall   = 1'b1;
            end
            default: b.ertn = 1'b1;
        endcase
        return b;
    endfunction

    // sends one instruction, checks its retire cycle, then updates the model.
    task automatic retire(input string name, input mem_wb_bus_t b);
        int          waited;
        logic        gr_we;
        logic [31:0] old_value;
        logic [31:0] wdata;
        logic [31:0] bits;
        logic [31:0] crmd;
        logic [31:0] prmd;
        logic [31:0] estat;
        wb_id_bus_t  exp_id;
        flush_t      exp_flush;
        waited = 0;
        while (wb_allowin !== 1'b1) begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > ALLOWIN_TIMEOUT) begin
                abort_run("timed out waiting for wb_allowin to go high");
            end
        end
        mem_wb_valid = 1'b1;
        mem_wb_bus   = b;
        @(posedge clk);
        #1;
        old_value          = expected_csr(b.csr_num);
        wdata              = (b.csr_re | b.csr_we) ? old_value : b.result;
        gr_we              = b.gr_we & ~b.syscall;
        exp_id.rf_we       = gr_we;
        exp_id.rf_waddr    = b.dest;
        exp_id.rf_wdata    = wdata;
        exp_flush.valid    = b.syscall | b.ertn;
        exp_flush.target   = b.syscall ? expected_csr(CSR_EENTRY) : expected_csr(CSR_ERA);
        check_word({name, " pc"}, b.pc, debug_wb_pc);
        check_word({name, " rf_we"}, {28'h0, {4{gr_we}}}, {28'h0, debug_wb_rf_we});
        check_word({name, " rf_wnum"}, {27'h0, b.dest}, {27'h0, debug_wb_rf_wnum});
        check_word({name, " rf_wdata"}, wdata, debug_wb_rf_wdata);
        check_id_bus({name, " wb_id_bus"}, exp_id, wb_id_bus);
        check_flush({name, " flush"}, exp_flush, flush);
        if (gr_we && b.dest != 5'd0) begin
            m_gr[b.dest]       = wdata;
            m_gr_known[b.dest] = 1'b1;
        end
        if (b.csr_we && !b.syscall && m_csr.exists(b.csr_num)) begin
            bits             = b.csr_wmask & writable_bits(b.csr_num);
            m_csr[b.csr_num] = (old_value & ~bits) | (b.csr_wvalue & bits);
        end
        crmd  = m_csr[CSR_CRMD];
        prmd  = m_csr[CSR_PRMD];
        estat = m_csr[CSR_ESTAT];
        if (b.syscall) begin
            prmd[2:0]    = crmd[2:0];
            crmd[2:0]    = 3'b000;
            estat[21:16] = ECODE_SYS;
            estat[30:22] = 9'h000;
            m_csr[CSR_ERA]   = b.pc;
            m_csr[CSR_PRMD]  = prmd;
            m_csr[CSR_ESTAT] = estat;
            m_csr[CSR_CRMD]  = crmd;
        end else if (b.ertn) begin
            crmd[2:0]       = prmd[2:0];
            m_csr[CSR_CRMD] = crmd;
        end
    endtask

    // idles one cycle so any pending write lands, then reads both ports.
    task automatic read_gr(input string name, input logic [4:0] addr);
        logic [4:0] addr2;
        mem_wb_valid = 1'b0;
        addr2        = ~addr;
        rf_raddr1    = addr;
        rf_raddr2    = addr2;
        @(posedge clk);
        #1;
        if (addr == 5'd0 || m_gr_known[addr]) begin
            check_word({name, " rdata1"}, expected_gr(addr), rf_rdata1);
        end
        if (addr2 == 5'd0 || m_gr_known[addr2]) begin
            check_word({name, " rdata2"}, expected_gr(addr2), rf_rdata2);
        end
    endtask

    task automatic csr_read(input logic [13:0] num, output logic [31:0] value);
        mem_wb_bus_t b;
        b         = make_instr(1);
        b.csr_num = num;
        retire("csrrd", b);
        value = debug_wb_rf_wdata;
    endtask

    initial begin
        mem_wb_bus_t b;
        logic [31:0] v;
        logic [31:0] old_crmd;
        logic [31:0] old_estat;
        logic [31:0] sys_pc;
        logic [31:0] prmd_v;
        void'($urandom(32'hbea8_a74d));
        clk          = 1'b0;
        resetn       = 1'b0;
        mem_wb_valid = 1'b0;
        mem_wb_bus   = '0;
        rf_raddr1    = 5'd0;
        rf_raddr2    = 5'd0;
        reset_model();
        repeat (8) @(posedge clk);
        #1;
        resetn = 1'b1;
        check_word("reset debug rf_we", 32'h0, {28'h0, debug_wb_rf_we});
        check_word("reset wb_id_bus rf_we", 32'h0, {31'h0, wb_id_bus.rf_we});
        check_word("reset flush valid", 32'h0, {31'h0, flush.valid});

        for (int i = 0; i < 40; i++) begin
            b = make_instr(0);
            retire("alu", b);
            read_gr("alu readback", b.dest);
        end
        b       = make_instr(0);
        b.dest  = 5'd0;
        b.gr_we = 1'b1;
        retire("alu r0", b);
        read_gr("r0 readback", 5'd0);

        for (int i = 0; i < 10; i++) begin
            b         = make_instr(3);
            b.csr_num = csr_list[i];
            retire("csrxchg", b);
            b         = make_instr(2);
            b.csr_num = csr_list[i];
            retire("csrwr", b);
            csr_read(csr_list[i], v);
        end

        // read-only fields.
        old_estat = expected_csr(CSR_ESTAT);
        foreach (csr_list[i]) begin
            if (i == 0 || i == 2 || i == 4) begin
                b            = make_instr(2);
                b.csr_num    = csr_list[i];
                b.csr_wvalue = 32'hffff_ffff;
                retire("csrwr ones", b);
            end
        end
        csr_read(CSR_CRMD, v);
        check_word("crmd da bit", 32'h1, {31'h0, v[3]});
        csr_read(CSR_EENTRY, v);
        check_word("eentry low bits", 32'h0, {26'h0, v[5:0]});
        csr_read(CSR_ESTAT, v);
        check_word("estat ecode", {26'h0, old_estat[21:16]}, {26'h0, v[21:16]});

        b         = make_instr(2);
        b.csr_num = CSR_CRMD;
        retire("set crmd", b);
        b         = make_instr(2);
        b.csr_num = CSR_EENTRY;
        retire("set eentry", b);
        old_crmd = expected_csr(CSR_CRMD);
        b       = make_instr(4);
        b.gr_we = 1'b1; // must still write nothing.
        sys_pc  = b.pc;
        retire("syscall", b);
        csr_read(CSR_ERA, v);
        check_word("syscall era", sys_pc, v);
        csr_read(CSR_ESTAT, v);
        check_word("syscall ecode", {26'h0, ECODE_SYS}, {26'h0, v[21:16]});
        csr_read(CSR_PRMD, v);
        check_word("syscall prmd", {29'h0, old_crmd[2:0]}, {29'h0, v[2:0]});
        csr_read(CSR_CRMD, v);
        check_word("syscall crmd", 32'h0, {29'h0, v[2:0]});

        b         = make_instr(2);
        b.csr_num = CSR_PRMD;
        retire("set prmd", b);
        prmd_v = expected_csr(CSR_PRMD);
        retire("ertn", make_instr(5));
        csr_read(CSR_CRMD, v);
        check_word("ertn crmd", {29'h0, prmd_v[2:0]}, {29'h0, v[2:0]});

        // mem_wb_valid stays high for the whole stream.
        for (int i = 0; i < STREAM_LEN; i++) begin
            check_word("stream allowin", 32'h1, {31'h0, wb_allowin});
            retire("stream", make_instr($urandom_range(5, 0)));
        end
        for (int i = 0; i < 32; i++) begin
            read_gr("final sweep", 5'(i));
        end

        $display("Everything OK");
        $finish;
    end

endmodule

//--- files.f
design/retire_pkg.sv
design/wb_stage.sv
design/csr_file.sv
design/reg_file.sv
design/retire_top.sv
bench/tb_retire_top.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_retire_top -f files.f
output=$(./obj_dir/Vtb_retire_top || true)
echo "$output"
if echo "$output" | grep -q "Everything OK"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1
